// File: project.f
source/cache_geom_pkg.sv
source/cache_port_pkg.sv
source/sram_1rw.sv
source/dir_array_ctrl.sv
source/dir_hit_logic.sv
source/victim_select.sv
source/data_array_ctrl.sv
source/cache_memctrl_top.sv
verification/cache_memctrl_assert.sv
verification/tb_cache_memctrl.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module tb_cache_memctrl -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation ended with status $status"
    exit $status
fi
exit 0

// File: verification/tb_cache_memctrl.sv
// ------------------------------
// Cache RAM controller testbench
// with a reference model
// ------------------------------
`timescale 1ns/1ps

module tb_cache_memctrl;
    localparam int SETS  = cache_geom_pkg::SETS;
    localparam int WAYS  = cache_geom_pkg::WAYS;
    localparam int WORDS = cache_geom_pkg::WORDS;
    // Tests take about 350 cycles, the limit leaves a wide margin
    localparam int MAX_CYCLES = 2000;

    logic                         clk_i  = 1'b0;
    logic                         rst_ni = 1'b1;
    logic                         ready_o;
    logic                         dir_match_i;
    cache_port_pkg::dir_lookup_t  dir_match_req_i;
    logic                         dir_updt_i;
    cache_port_pkg::dir_write_t   dir_updt_req_i;
    logic                         dir_refill_i;
    cache_port_pkg::dir_write_t   dir_refill_req_i;
    logic                         dir_refill_sel_victim_i;
    logic                         data_read_i;
    cache_port_pkg::data_read_t   data_read_req_i;
    logic                         data_write_i;
    cache_port_pkg::data_write_t  data_write_req_i;
    logic                         data_refill_i;
    cache_port_pkg::data_refill_t data_refill_req_i;
    cache_geom_pkg::way_vec_t     dir_hit_way_o;
    cache_geom_pkg::tag_t         dir_hit_tag_o;
    logic                         dir_hit_dirty_o;
    cache_geom_pkg::way_vec_t     dir_victim_way_o;
    logic                         dir_victim_valid_o;
    logic                         dir_victim_dirty_o;
    cache_geom_pkg::tag_t         dir_victim_tag_o;
    cache_geom_pkg::data_word_t   read_data_o;

    // Reference model of directory, pointers and data
    logic                 m_valid [SETS][WAYS];
    logic                 m_dirty [SETS][WAYS];
    cache_geom_pkg::tag_t m_tag   [SETS][WAYS];
    int                   m_ptr   [SETS];
    logic [31:0]          m_data  [SETS][WAYS][WORDS];

    integer seed      = 32'hfb7f_608d;
    int     cycle_cnt = 0;
    int     last_vic;

    cache_memctrl_top UUT (.*);

    always #20 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycle_cnt);
            abort_run();
        end
    end

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1, "Run stopped at %0t", $time);
    endtask

    task automatic check_equal(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run();
        end
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic advance_cycle();
        @(posedge clk_i);
        #2;
    endtask

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // Random tag that no valid way of the set holds
    function automatic cache_geom_pkg::tag_t fresh_tag(input int s);
        cache_geom_pkg::tag_t t;
        logic                 taken;
        do begin
            t     = 8'($random(seed));
            taken = 1'b0;
            for (int w = 0; w < WAYS; w++) begin
                taken |= m_valid[s][w] && (m_tag[s][w] == t);
            end
        end while (taken);
        return t;
    endfunction

    // Lookup with a read of the same set, outputs checked one cycle later
    task automatic lookup_and_check(input int s, input cache_geom_pkg::tag_t t, input int wd);
        cache_geom_pkg::way_vec_t exp_hit;
        int                       hit_idx;
        int                       vic_idx;
        exp_hit = '0;
        hit_idx = -1;
        vic_idx = -1;
        for (int w = 0; w < WAYS; w++) begin
            if (m_valid[s][w] && m_tag[s][w] == t) begin
                exp_hit[w] = 1'b1;
                hit_idx    = w;
            end
            if (!m_valid[s][w] && vic_idx < 0) begin
                vic_idx = w;
            end
        end
        // Full set falls back to the round-robin pointer
        if (vic_idx < 0) begin
            vic_idx = m_ptr[s];
        end
        last_vic = vic_idx;
        dir_match_i          = 1'b1;
        dir_match_req_i.set  = cache_geom_pkg::set_t'(s);
        dir_match_req_i.tag  = t;
        data_read_i          = 1'b1;
        data_read_req_i.set  = cache_geom_pkg::set_t'(s);
        data_read_req_i.word = cache_geom_pkg::word_idx_t'(wd);
        advance_cycle();
        dir_match_i = 1'b0;
        data_read_i = 1'b0;
        check_equal("dir_hit_way_o", 32'(dir_hit_way_o), 32'(exp_hit));
        if (hit_idx >= 0) begin
            check_equal("dir_hit_tag_o", 32'(dir_hit_tag_o), 32'(t));
            check_equal("dir_hit_dirty_o", 32'(dir_hit_dirty_o), 32'(m_dirty[s][hit_idx]));
            check_equal("read_data_o", read_data_o, m_data[s][hit_idx][wd]);
        end else begin
            check_equal("read_data_o", read_data_o, 32'h0);
        end
        check_equal("dir_victim_way_o", 32'(dir_victim_way_o), 32'(1 << vic_idx));
        check_equal("dir_victim_valid_o", 32'(dir_victim_valid_o), 32'(m_valid[s][vic_idx]));
        check_equal("dir_victim_dirty_o", 32'(dir_victim_dirty_o), 32'(m_dirty[s][vic_idx]));
        check_equal("dir_victim_tag_o", 32'(dir_victim_tag_o), 32'(m_tag[s][vic_idx]));
    endtask

    // Directory entry with the first data word, then the other three words
    task automatic refill_line(input int s, input int w, input cache_geom_pkg::tag_t t,
                               input logic sel);
        dir_refill_i                 = 1'b1;
        dir_refill_sel_victim_i      = sel;
        dir_refill_req_i.set         = cache_geom_pkg::set_t'(s);
        dir_refill_req_i.way         = cache_geom_pkg::way_vec_t'(1 << w);
        dir_refill_req_i.entry.valid = 1'b1;
        dir_refill_req_i.entry.dirty = 1'b0;
        dir_refill_req_i.entry.tag   = t;
        data_refill_i                = 1'b1;
        for (int wd = 0; wd < WORDS; wd++) begin
            data_refill_req_i.set  = cache_geom_pkg::set_t'(s);
            data_refill_req_i.way  = cache_geom_pkg::way_vec_t'(1 << w);
            data_refill_req_i.word = cache_geom_pkg::word_idx_t'(wd);
            data_refill_req_i.data = $random(seed);
            m_data[s][w][wd]       = data_refill_req_i.data;
            advance_cycle();
            dir_refill_i            = 1'b0;
            dir_refill_sel_victim_i = 1'b0;
        end
        data_refill_i = 1'b0;
        m_valid[s][w] = 1'b1;
        m_dirty[s][w] = 1'b0;
        m_tag[s][w]   = t;
        if (sel) begin
            m_ptr[s] = (w + 1) % WAYS;
        end
    endtask

    // Miss lookup, refill of the victim way, then all words read back
    task automatic refill_victim(input int s, input logic sel);
        cache_geom_pkg::tag_t t;
        int                   w;
        t = fresh_tag(s);
        lookup_and_check(s, t, 0);
        w = last_vic;
        refill_line(s, w, t, sel);
        for (int wd = 0; wd < WORDS; wd++) begin
            lookup_and_check(s, t, wd);
        end
    endtask

    // Lands in the hit way of the lookup just before
    task automatic write_word(input int s, input int w, input int wd);
        cache_geom_pkg::data_word_t d;
        cache_geom_pkg::byte_en_t   be;
        d  = $random(seed);
        be = 4'($random(seed));
        data_write_i          = 1'b1;
        data_write_req_i.set  = cache_geom_pkg::set_t'(s);
        data_write_req_i.word = cache_geom_pkg::word_idx_t'(wd);
        data_write_req_i.data = d;
        data_write_req_i.be   = be;
        advance_cycle();
        data_write_i = 1'b0;
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                m_data[s][w][wd][8*b +: 8] = d[8*b +: 8];
            end
        end
    endtask

    task automatic update_entry(input int s, input int w);
        dir_updt_i                 = 1'b1;
        dir_updt_req_i.set         = cache_geom_pkg::set_t'(s);
        dir_updt_req_i.way         = cache_geom_pkg::way_vec_t'(1 << w);
        dir_updt_req_i.entry.valid = 1'b1;
        dir_updt_req_i.entry.dirty = 1'b1;
        dir_updt_req_i.entry.tag   = m_tag[s][w];
        advance_cycle();
        dir_updt_i    = 1'b0;
        m_dirty[s][w] = 1'b1;
    endtask

    // Valid line found by scanning from a random set and way
    task automatic pick_line(output int s, output int w);
        int base;
        int k;
        s    = -1;
        w    = -1;
        base = rand_below(SETS * WAYS);
        for (int i = 0; i < SETS * WAYS; i++) begin
            k = (base + i) % (SETS * WAYS);
            if (s < 0 && m_valid[k / WAYS][k % WAYS]) begin
                s = k / WAYS;
                w = k % WAYS;
            end
        end
        if (s < 0) begin
            $display("No valid cache line in the model to test on");
            abort_run();
        end
    endtask

    initial begin
        int                   ready_cycles;
        int                   s;
        int                   w;
        int                   wd;
        int                   full_s;
        cache_geom_pkg::tag_t t;
        rst_ni                  = 1'b0;
        dir_match_i             = 1'b0;
        dir_updt_i              = 1'b0;
        dir_refill_i            = 1'b0;
        dir_refill_sel_victim_i = 1'b0;
        data_read_i             = 1'b0;
        data_write_i            = 1'b0;
        data_refill_i           = 1'b0;
        dir_match_req_i         = '0;
        dir_updt_req_i          = '0;
        dir_refill_req_i        = '0;
        data_read_req_i         = '0;
        data_write_req_i        = '0;
        data_refill_req_i       = '0;
        for (int i = 0; i < SETS; i++) begin
            m_ptr[i] = 0;
            for (int j = 0; j < WAYS; j++) begin
                m_valid[i][j] = 1'b0;
                m_dirty[i][j] = 1'b0;
                m_tag[i][j]   = '0;
            end
        end

        // Reset, then the clear sweep of one set per cycle
        repeat (3) begin
            @(posedge clk_i);
            #1;
            check_equal("ready_o", 32'(ready_o), 32'h0);
        end
        #1;
        rst_ni       = 1'b1;
        ready_cycles = 0;
        while (!ready_o) begin
            advance_cycle();
            ready_cycles++;
        end
        check_equal("ready_o low cycles", 32'(ready_cycles), 32'(SETS));

        for (s = 0; s < SETS; s++) begin
            lookup_and_check(s, 8'($random(seed)), rand_below(WORDS));
        end

        // Refills into random sets through the victim choice
        repeat (12) begin
            refill_victim(rand_below(SETS), 1'b1);
        end

        // One set filled past capacity, pointer walks the ways
        s      = rand_below(SETS);
        full_s = s;
        repeat (9) begin
            refill_victim(s, 1'b1);
        end
        // Refill without victim select leaves the pointer alone
        w = rand_below(WAYS);
        t = fresh_tag(s);
        refill_line(s, w, t, 1'b0);
        lookup_and_check(s, t, rand_below(WORDS));
        repeat (3) begin
            refill_victim(s, 1'b1);
        end

        repeat (16) begin
            pick_line(s, w);
            wd = rand_below(WORDS);
            lookup_and_check(s, m_tag[s][w], wd);
            write_word(s, w, wd);
            lookup_and_check(s, m_tag[s][w], wd);
        end

        // Dirty update, then a miss with another tag
        repeat (6) begin
            pick_line(s, w);
            update_entry(s, w);
            lookup_and_check(s, m_tag[s][w], rand_below(WORDS));
            lookup_and_check(s, fresh_tag(s), rand_below(WORDS));
        end

        // Dirty way under the pointer of the full set comes out as a dirty victim
        update_entry(full_s, m_ptr[full_s]);
        lookup_and_check(full_s, fresh_tag(full_s), rand_below(WORDS));

        $display("NO ERRORS");
        $finish;
    end

endmodule

// File: verification/cache_memctrl_assert.sv
// ------------------------------
// Strobe and reset assertions,
// bound to the controller top
// ------------------------------
`timescale 1ns/1ps

module cache_memctrl_assert (
    input logic clk_i,
    input logic rst_ni,
    input logic ready_i,
    input logic dir_match_i,
    input logic dir_updt_i,
    input logic dir_refill_i,
    input logic data_read_i,
    input logic data_write_i,
    input logic data_refill_i
);
    logic [2:0] dir_strobes;
    logic [2:0] data_strobes;

    assign dir_strobes  = {dir_match_i, dir_updt_i, dir_refill_i};
    assign data_strobes = {data_read_i, data_write_i, data_refill_i};

    dir_strobe_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(dir_strobes))
        else $error("More than one directory strobe in a cycle");

    data_strobe_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(data_strobes))
        else $error("More than one data strobe in a cycle");

    // Nothing may arrive during the clear sweep
    no_strobe_early: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !ready_i |-> (dir_strobes == 3'b000 && data_strobes == 3'b000))
        else $error("Strobe raised before ready");

    ready_low_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !ready_i)
        else $error("Ready high during reset");

    // Sweep covers one set per cycle after release
    ready_after_sweep: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(rst_ni) |-> ##(cache_geom_pkg::SETS - 1) !ready_i ##1 ready_i)
        else $error("Ready did not rise right after the clear sweep");

endmodule

bind cache_memctrl_top cache_memctrl_assert u_assert (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ready_i       (ready_o),
    .dir_match_i   (dir_match_i),
    .dir_updt_i    (dir_updt_i),
    .dir_refill_i  (dir_refill_i),
    .data_read_i   (data_read_i),
    .data_write_i  (data_write_i),
    .data_refill_i (data_refill_i)
);

// File: source/cache_memctrl_top.sv
// ------------------------------
// Directory and data RAM
// controller, top level
// ------------------------------
`timescale 1ns/1ps

module cache_memctrl_top (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    output logic                        ready_o,

    input  logic                        dir_match_i,
    input  cache_port_pkg::dir_lookup_t dir_match_req_i,
    input  logic                        dir_updt_i,
    input  cache_port_pkg::dir_write_t  dir_updt_req_i,
    input  logic                        dir_refill_i,
    input  cache_port_pkg::dir_write_t  dir_refill_req_i,
    input  logic                        dir_refill_sel_victim_i,

    input  logic                        data_read_i,
    input  cache_port_pkg::data_read_t  data_read_req_i,
    input  logic                        data_write_i,
    input  cache_port_pkg::data_write_t data_write_req_i,
    input  logic                        data_refill_i,
    input  cache_port_pkg::data_refill_t data_refill_req_i,

    output cache_geom_pkg::way_vec_t    dir_hit_way_o,
    output cache_geom_pkg::tag_t        dir_hit_tag_o,
    output logic                        dir_hit_dirty_o,
    output cache_geom_pkg::way_vec_t    dir_victim_way_o,
    output logic                        dir_victim_valid_o,
    output logic                        dir_victim_dirty_o,
    output cache_geom_pkg::tag_t        dir_victim_tag_o,
    output cache_geom_pkg::data_word_t  read_data_o
);
    localparam int unsigned DIR_DEPTH  = cache_geom_pkg::SETS;
    localparam int unsigned DIR_WIDTH  = $bits(cache_port_pkg::dir_entry_t);
    localparam int unsigned DATA_DEPTH = cache_geom_pkg::SETS * cache_geom_pkg::WORDS;
    localparam int unsigned DATA_WIDTH = cache_geom_pkg::WORD_W;

    cache_port_pkg::dir_entry_t [cache_geom_pkg::WAYS-1:0] rd_entries;
    cache_geom_pkg::set_t                                  lookup_set;
    cache_geom_pkg::tag_t                                  lookup_tag;
    logic                                                  victim_refill;

    // Only refills that asked for it move the round-robin pointer
    assign victim_refill = dir_refill_i & dir_refill_sel_victim_i;

    dir_array_ctrl #(
        .DIR_DEPTH (DIR_DEPTH),
        .DIR_WIDTH (DIR_WIDTH)
    ) u_dir_array (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .ready_o          (ready_o),
        .dir_match_i      (dir_match_i),
        .dir_match_req_i  (dir_match_req_i),
        .dir_updt_i       (dir_updt_i),
        .dir_updt_req_i   (dir_updt_req_i),
        .dir_refill_i     (dir_refill_i),
        .dir_refill_req_i (dir_refill_req_i),
        .rd_entries_o     (rd_entries),
        .lookup_set_o     (lookup_set),
        .lookup_tag_o     (lookup_tag)
    );

    victim_select u_victim (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .rd_entries_i (rd_entries),
        .lookup_set_i (lookup_set),
        .refill_i     (victim_refill),
        .refill_set_i (dir_refill_req_i.set),
        .refill_way_i (dir_refill_req_i.way),
        .victim_way_o (dir_victim_way_o)
    );

    dir_hit_logic u_hit (
        .rd_entries_i   (rd_entries),
        .lookup_tag_i   (lookup_tag),
        .victim_way_i   (dir_victim_way_o),
        .hit_way_o      (dir_hit_way_o),
        .hit_tag_o      (dir_hit_tag_o),
        .hit_dirty_o    (dir_hit_dirty_o),
        .victim_tag_o   (dir_victim_tag_o),
        .victim_valid_o (dir_victim_valid_o),
        .victim_dirty_o (dir_victim_dirty_o)
    );

    data_array_ctrl #(
        .DATA_DEPTH (DATA_DEPTH),
        .DATA_WIDTH (DATA_WIDTH)
    ) u_data_array (
        .clk_i             (clk_i),
        .data_read_i       (data_read_i),
        .data_read_req_i   (data_read_req_i),
        .data_write_i      (data_write_i),
        .data_write_req_i  (data_write_req_i),
        .data_refill_i     (data_refill_i),
        .data_refill_req_i (data_refill_req_i),
        .hit_way_i         (dir_hit_way_o),
        .read_data_o       (read_data_o)
    );

endmodule

// File: source/data_array_ctrl.sv
// ------------------------------
// Data RAMs with write select,
// byte masks and read way mux
// ------------------------------
`timescale 1ns/1ps

module data_array_ctrl #(
    parameter int unsigned DATA_DEPTH = 64,
    parameter int unsigned DATA_WIDTH = 32
) (
    input  logic                         clk_i,
    input  logic                         data_read_i,
    input  cache_port_pkg::data_read_t   data_read_req_i,
    input  logic                         data_write_i,
    input  cache_port_pkg::data_write_t  data_write_req_i,
    input  logic                         data_refill_i,
    input  cache_port_pkg::data_refill_t data_refill_req_i,
    input  cache_geom_pkg::way_vec_t     hit_way_i,
    output cache_geom_pkg::data_word_t   read_data_o
);
    cache_geom_pkg::data_addr_t                        ram_addr;
    cache_geom_pkg::way_vec_t                          ram_cs;
    cache_geom_pkg::way_vec_t                          ram_we;
    logic [DATA_WIDTH-1:0]                             ram_wdata;
    logic [DATA_WIDTH-1:0]                             ram_wmask;
    logic [cache_geom_pkg::WAYS-1:0][DATA_WIDTH-1:0]   ram_rdata;

    always_comb begin
        ram_addr  = '0;
        ram_cs    = '0;
        ram_we    = '0;
        ram_wdata = '0;
        ram_wmask = '0;
        unique case (1'b1)
            // Full word into the refilled way
            data_refill_i: begin
                ram_addr  = {data_refill_req_i.set, data_refill_req_i.word};
                ram_cs    = data_refill_req_i.way;
                ram_we    = data_refill_req_i.way;
                ram_wdata = data_refill_req_i.data;
                ram_wmask = '1;
            end
            // Byte write into the hit way, nothing on a miss
            data_write_i: begin
                ram_addr  = {data_write_req_i.set, data_write_req_i.word};
                ram_cs    = hit_way_i;
                ram_we    = hit_way_i;
                ram_wdata = data_write_req_i.data;
                for (int b = 0; b < DATA_WIDTH / 8; b++) begin
                    ram_wmask[8*b +: 8] = {8{data_write_req_i.be[b]}};
                end
            end
            // All ways read, hit way picks one next cycle
            data_read_i: begin
                ram_addr = {data_read_req_i.set, data_read_req_i.word};
                ram_cs   = '1;
            end
            default: begin
                // Idle
            end
        endcase
    end

    for (genvar w = 0; w < cache_geom_pkg::WAYS; w++) begin : gen_data_ram
        sram_1rw #(
            .DEPTH (DATA_DEPTH),
            .WIDTH (DATA_WIDTH)
        ) u_ram (
            .clk_i   (clk_i),
            .cs_i    (ram_cs[w]),
            .we_i    (ram_we[w]),
            .addr_i  (ram_addr),
            .wdata_i (ram_wdata),
            .wmask_i (ram_wmask),
            .rdata_o (ram_rdata[w])
        );
    end

    // Zero on a miss
    always_comb begin
        read_data_o = '0;
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            read_data_o |= ram_rdata[w] & {DATA_WIDTH{hit_way_i[w]}};
        end
    end

endmodule

// File: source/victim_select.sv
// ------------------------------
// Per-set round-robin pointers
// and victim way choice
// ------------------------------
`timescale 1ns/1ps

module victim_select (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  cache_port_pkg::dir_entry_t [cache_geom_pkg::WAYS-1:0] rd_entries_i,
    input  cache_geom_pkg::set_t     lookup_set_i,
    input  logic                     refill_i,
    input  cache_geom_pkg::set_t     refill_set_i,
    input  cache_geom_pkg::way_vec_t refill_way_i,
    output cache_geom_pkg::way_vec_t victim_way_o
);
    localparam int unsigned PTR_W = $clog2(cache_geom_pkg::WAYS);

    logic [cache_geom_pkg::SETS-1:0][PTR_W-1:0] ptr_q;
    logic [PTR_W-1:0]                           refill_idx;
    cache_geom_pkg::way_vec_t                   invalid_ways;
    cache_geom_pkg::way_vec_t                   ptr_way;

    always_comb begin
        refill_idx = '0;
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            if (refill_way_i[w]) begin
                refill_idx = w[PTR_W-1:0];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            invalid_ways[w] = !rd_entries_i[w].valid;
        end
    end

    assign ptr_way = cache_geom_pkg::way_vec_t'(1) << ptr_q[lookup_set_i];

    // Lowest invalid way first, x & -x keeps its lowest set bit
    assign victim_way_o = (|invalid_ways) ? (invalid_ways & (~invalid_ways + 1'b1)) : ptr_way;

    // Pointer moves past the refilled way
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (refill_i) begin
            if (refill_idx == PTR_W'(cache_geom_pkg::WAYS - 1)) begin
                ptr_q[refill_set_i] <= '0;
            end else begin
                ptr_q[refill_set_i] <= refill_idx + 1'b1;
            end
        end
    end

endmodule

// File: source/dir_hit_logic.sv
// ------------------------------
// Tag compare, hit and victim
// entry selection
// ------------------------------
`timescale 1ns/1ps

module dir_hit_logic (
    input  cache_port_pkg::dir_entry_t [cache_geom_pkg::WAYS-1:0] rd_entries_i,
    input  cache_geom_pkg::tag_t     lookup_tag_i,
    input  cache_geom_pkg::way_vec_t victim_way_i,
    output cache_geom_pkg::way_vec_t hit_way_o,
    output cache_geom_pkg::tag_t     hit_tag_o,
    output logic                     hit_dirty_o,
    output cache_geom_pkg::tag_t     victim_tag_o,
    output logic                     victim_valid_o,
    output logic                     victim_dirty_o
);
    cache_port_pkg::dir_entry_t hit_entry;
    cache_port_pkg::dir_entry_t victim_entry;

    // One-hot AND-OR select, all zero when nothing is selected
    function automatic cache_port_pkg::dir_entry_t sel_entry(
        input cache_port_pkg::dir_entry_t [cache_geom_pkg::WAYS-1:0] entries,
        input cache_geom_pkg::way_vec_t                              sel
    );
        cache_port_pkg::dir_entry_t res;
        res = '0;
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            res |= entries[w] & {$bits(res){sel[w]}};
        end
        return res;
    endfunction

    always_comb begin
        for (int w = 0; w < cache_geom_pkg::WAYS; w++) begin
            hit_way_o[w] = rd_entries_i[w].valid && (rd_entries_i[w].tag == lookup_tag_i);
        end
    end

    assign hit_entry    = sel_entry(rd_entries_i, hit_way_o);
    assign victim_entry = sel_entry(rd_entries_i, victim_way_i);

    assign hit_tag_o      = hit_entry.tag;
    assign hit_dirty_o    = hit_entry.dirty;
    assign victim_tag_o   = victim_entry.tag;
    assign victim_valid_o = victim_entry.valid;
    assign victim_dirty_o = victim_entry.dirty;

endmodule

// File: source/dir_array_ctrl.sv
// ------------------------------
// Directory clear sequencer,
// request select and RAMs
// ------------------------------
`timescale 1ns/1ps

module dir_array_ctrl #(
    parameter int unsigned DIR_DEPTH = 16,
    parameter int unsigned DIR_WIDTH = 10
) (
    input  logic                        clk_i,
    input  logic                        rst_ni,
    output logic                        ready_o,
    input  logic                        dir_match_i,
    input  cache_port_pkg::dir_lookup_t dir_match_req_i,
    input  logic                        dir_updt_i,
    input  cache_port_pkg::dir_write_t  dir_updt_req_i,
    input  logic                        dir_refill_i,
    input  cache_port_pkg::dir_write_t  dir_refill_req_i,
    output cache_port_pkg::dir_entry_t [cache_geom_pkg::WAYS-1:0] rd_entries_o,
    output cache_geom_pkg::set_t        lookup_set_o,
    output cache_geom_pkg::tag_t        lookup_tag_o
);
    logic                       init_q;
    cache_geom_pkg::set_t       init_set_q;
    cache_geom_pkg::set_t       dir_addr;
    cache_geom_pkg::way_vec_t   dir_cs;
    cache_geom_pkg::way_vec_t   dir_we;
    cache_port_pkg::dir_entry_t dir_wentry;

    // Clear sweep, one set per cycle, then ready for good
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            init_q     <= 1'b0;
            init_set_q <= '0;
        end else if (!init_q) begin
            init_q     <= (init_set_q == cache_geom_pkg::set_t'(DIR_DEPTH - 1));
            init_set_q <= init_set_q + 1'b1;
        end
    end

    assign ready_o = init_q;

    // Strobes are exclusive, so no priority among them
    always_comb begin
        dir_addr   = '0;
        dir_cs     = '0;
        dir_we     = '0;
        dir_wentry = '0;
        unique case (1'b1)
            !init_q: begin
                dir_addr = init_set_q;
                dir_cs   = '1;
                dir_we   = '1;
            end
            dir_match_i: begin
                dir_addr = dir_match_req_i.set;
                dir_cs   = '1;
            end
            dir_updt_i: begin
                dir_addr   = dir_updt_req_i.set;
                dir_cs     = dir_updt_req_i.way;
                dir_we     = dir_updt_req_i.way;
                dir_wentry = dir_updt_req_i.entry;
            end
            dir_refill_i: begin
                dir_addr   = dir_refill_req_i.set;
                dir_cs     = dir_refill_req_i.way;
                dir_we     = dir_refill_req_i.way;
                dir_wentry = dir_refill_req_i.entry;
            end
            default: begin
                // Idle
            end
        endcase
    end

    // Lookup set and tag for the hit and victim logic of the next cycle
    always_ff @(posedge clk_i) begin
        if (dir_match_i) begin
            lookup_set_o <= dir_match_req_i.set;
            lookup_tag_o <= dir_match_req_i.tag;
        end
    end

    for (genvar w = 0; w < cache_geom_pkg::WAYS; w++) begin : gen_dir_ram
        sram_1rw #(
            .DEPTH (DIR_DEPTH),
            .WIDTH (DIR_WIDTH)
        ) u_ram (
            .clk_i   (clk_i),
            .cs_i    (dir_cs[w]),
            .we_i    (dir_we[w]),
            .addr_i  (dir_addr),
            .wdata_i (dir_wentry),
            .wmask_i ({DIR_WIDTH{1'b1}}),
            .rdata_o (rd_entries_o[w])
        );
    end

endmodule

// File: source/sram_1rw.sv
// ------------------------------
// Single-port RAM, bit write
// mask, registered read
// ------------------------------
`timescale 1ns/1ps

module sram_1rw #(
    parameter int unsigned DEPTH = 16,
    parameter int unsigned WIDTH = 32
) (
    input  logic                     clk_i,
    input  logic                     cs_i,
    input  logic                     we_i,
    input  logic [$clog2(DEPTH)-1:0] addr_i,
    input  logic [WIDTH-1:0]         wdata_i,
    input  logic [WIDTH-1:0]         wmask_i,
    output logic [WIDTH-1:0]         rdata_o
);
    logic [WIDTH-1:0] mem_q [DEPTH];

    // Read data holds unless a read is done
    always_ff @(posedge clk_i) begin
        if (cs_i) begin
            if (we_i) begin
                mem_q[addr_i] <= (mem_q[addr_i] & ~wmask_i) | (wdata_i & wmask_i);
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

// File: source/cache_port_pkg.sv
// ------------------------------
// Directory entry and request
// records of the controller
// ------------------------------
package cache_port_pkg;

    // Directory RAM word
    typedef struct packed {
        logic                 valid;
        logic                 dirty;
        cache_geom_pkg::tag_t tag;
    } dir_entry_t;

    // Tag lookup
    typedef struct packed {
        cache_geom_pkg::set_t set;
        cache_geom_pkg::tag_t tag;
    } dir_lookup_t;

    // Directory update or refill of one way
    typedef struct packed {
        cache_geom_pkg::set_t     set;
        cache_geom_pkg::way_vec_t way;
        dir_entry_t               entry;
    } dir_write_t;

    typedef struct packed {
        cache_geom_pkg::set_t      set;
        cache_geom_pkg::word_idx_t word;
    } data_read_t;

    // Write goes to the hit way, so no way field here
    typedef struct packed {
        cache_geom_pkg::set_t       set;
        cache_geom_pkg::word_idx_t  word;
        cache_geom_pkg::data_word_t data;
        cache_geom_pkg::byte_en_t   be;
    } data_write_t;

    typedef struct packed {
        cache_geom_pkg::set_t       set;
        cache_geom_pkg::way_vec_t   way;
        cache_geom_pkg::word_idx_t  word;
        cache_geom_pkg::data_word_t data;
    } data_refill_t;

endpackage

// File: source/cache_geom_pkg.sv
// ------------------------------
// Cache geometry constants and
// basic index and data types
// ------------------------------
package cache_geom_pkg;

    // Geometry
    localparam int unsigned SETS   = 16;
    localparam int unsigned WAYS   = 4;
    localparam int unsigned WORDS  = 4;
    localparam int unsigned WORD_W = 32;
    localparam int unsigned TAG_W  = 8;

    localparam int unsigned SET_W      = $clog2(SETS);
    localparam int unsigned WORD_IDX_W = $clog2(WORDS);

    // Index and tag fields
    typedef logic [SET_W-1:0]      set_t;
    typedef logic [TAG_W-1:0]      tag_t;
    typedef logic [WORD_IDX_W-1:0] word_idx_t;

    // One bit per way, one-hot when selecting
    typedef logic [WAYS-1:0] way_vec_t;

    // Data word and its byte enables
    typedef logic [WORD_W-1:0]   data_word_t;
    typedef logic [WORD_W/8-1:0] byte_en_t;

    // Set in the upper bits, word in the lower bits
    typedef logic [SET_W+WORD_IDX_W-1:0] data_addr_t;

endpackage
